/* src/lsu_pkg.sv */
// LSU shared types
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // Sizing
  //////////////////////////////////////////////////

  // Outstanding bus transactions allowed by default
  parameter int unsigned LSU_DEPTH = 2;

  //////////////////////////////////////////////////
  // Word-level types
  //////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // Data and address word
  typedef logic [3:0]  be_t;        // One enable per byte lane
  typedef logic [1:0]  byte_off_t;  // Byte position inside a word

  //////////////////////////////////////////////////
  // Access encodings
  //////////////////////////////////////////////////

  // Access size as decoded in EX
  // Code 3 is not listed and decodes as a byte access
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,  // 32 bit
    DT_HALF = 2'b01,  // 16 bit
    DT_BYTE = 2'b10   // 8 bit
  } data_type_e;

  // Fill of the upper bits on halfword and byte loads
  // Code 3 is not listed and fills like EXT_SIGN
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,  // Unsigned load
    EXT_SIGN = 2'b01,  // Copy of the top loaded bit
    EXT_ONES = 2'b10   // All ones above the loaded part
  } sign_ext_e;

endpackage

`default_nettype wire

/* src/lsu_request_gen.sv */
// LSU request generation
`timescale 1ns/1ns
`default_nettype none

module lsu_request_gen (
  input  lsu_pkg::word_t     operand_a_i,        // Base register
  input  lsu_pkg::word_t     operand_b_i,        // Offset operand
  input  logic               addr_useincr_i,     // Add B to A when set
  input  lsu_pkg::data_type_e data_type_i,       // Access size
  input  lsu_pkg::word_t     data_wdata_i,       // Store data as read from the RF
  input  lsu_pkg::byte_off_t data_reg_offset_i,  // Lane of the store data inside the register
  input  logic               data_req_i,         // EX wants a bus access
  input  logic               data_misaligned_i,  // Second half of a split access
  output lsu_pkg::word_t     trans_addr_o,
  output lsu_pkg::be_t       trans_be_o,
  output lsu_pkg::word_t     trans_wdata_o,
  output lsu_pkg::byte_off_t addr_offset_o,      // Raw offset, kept in WB for alignment
  output logic               misaligned_o        // Needs a second access
);

  import lsu_pkg::*;

  word_t       addr_int;     // Effective address before word alignment
  byte_off_t   addr_off;
  byte_off_t   wdata_rot;    // Byte lanes to move the store data up by
  logic [63:0] wdata_dbl;    // Two copies for the rotate

  //////////////////////////////////////////////////
  // Address
  //////////////////////////////////////////////////

  assign addr_int = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr_int[1:0];

  assign addr_offset_o = addr_off;

  // Second half always starts at lane 0 of the next word
  assign trans_addr_o = data_misaligned_i ? {addr_int[31:2], 2'b00} : addr_int;

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  always_comb begin
    trans_be_o = 4'b0001;  // Byte, and the tail of a split halfword
    case (data_type_i)
      DT_WORD: begin
        if (data_misaligned_i) begin
          trans_be_o = ~(4'b1111 << addr_off);  // Lanes left over from the first half
        end else begin
          trans_be_o = 4'b1111 << addr_off;     // Upper lanes from the offset
        end
      end
      DT_HALF: begin
        // Offset 3 keeps only lane 3 here, lane 0 goes out in the second half
        if (!data_misaligned_i) begin
          trans_be_o = 4'b0011 << addr_off;
        end
      end
      default: trans_be_o = 4'b0001 << addr_off;  // Byte, code 3 included
    endcase
  end

  //////////////////////////////////////////////////
  // Store data
  //////////////////////////////////////////////////

  // Move the register lane onto the addressed lane, wraps mod 4
  assign wdata_rot = addr_off - data_reg_offset_i;

  // Upper half of the doubled word is the rotated word
  assign wdata_dbl     = {data_wdata_i, data_wdata_i} << {wdata_rot, 3'b000};
  assign trans_wdata_o = wdata_dbl[63:32];

  //////////////////////////////////////////////////
  // Misalignment
  //////////////////////////////////////////////////

  // Only a first half can be split, the second half is always aligned
  always_comb begin
    misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i) begin
      if (data_type_i == DT_WORD) begin
        misaligned_o = (addr_off != 2'b00);  // Any offset crosses the word
      end else if (data_type_i == DT_HALF) begin
        misaligned_o = (addr_off == 2'b11);  // Only the last lane crosses
      end
    end
  end

endmodule

`default_nettype wire

/* src/lsu_read_align.sv */
// LSU load data alignment
`timescale 1ns/1ns
`default_nettype none

module lsu_read_align (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ctrl_update_i,         // EX access moves to WB
  input  lsu_pkg::data_type_e data_type_i,
  input  lsu_pkg::sign_ext_e  data_sign_ext_i,
  input  lsu_pkg::byte_off_t  addr_offset_i,
  input  logic                data_we_i,
  input  logic                data_misaligned_ex_i,  // EX is on a second half
  input  logic                misaligned_i,          // EX is on a split first half
  input  logic                resp_valid_i,
  input  lsu_pkg::word_t      resp_rdata_i,
  output lsu_pkg::word_t      data_rdata_o           // To the register file
);

  import lsu_pkg::*;

  // WB-stage copy of the access attributes
  data_type_e  data_type_q;
  sign_ext_e   sign_ext_q;
  byte_off_t   rdata_offset_q;
  logic        data_we_q;
  logic        seen_update_q;  // First access has reached WB

  word_t       rdata_q;        // Partial word or last result
  word_t       rdata_shift;    // Response with the offset lane at bit 0
  logic [63:0] rdata_joined;   // Response above the saved first half
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;
  logic        fill_h;         // Upper bit fill for halfwords
  logic        fill_b;         // Upper bit fill for bytes
  word_t       rdata_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q    <= DT_WORD;
      sign_ext_q     <= EXT_ZERO;
      rdata_offset_q <= '0;
      data_we_q      <= 1'b0;
      seen_update_q  <= 1'b0;
    end else if (ctrl_update_i) begin
      data_type_q    <= data_type_i;
      sign_ext_q     <= data_sign_ext_i;
      rdata_offset_q <= addr_offset_i;
      data_we_q      <= data_we_i;
      seen_update_q  <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Lane selection and extension
  //////////////////////////////////////////////////

  assign rdata_shift  = resp_rdata_i >> {rdata_offset_q, 3'b000};
  assign rdata_joined = {resp_rdata_i, rdata_q} >> {rdata_offset_q, 3'b000};

  // Offset 3 halfword straddles the saved word and the response
  assign half_raw = (rdata_offset_q == 2'b11) ? rdata_joined[15:0] : rdata_shift[15:0];
  assign byte_raw = rdata_shift[7:0];

  always_comb begin
    case (sign_ext_q)
      EXT_ZERO: begin
        fill_h = 1'b0;
        fill_b = 1'b0;
      end
      EXT_ONES: begin
        fill_h = 1'b1;
        fill_b = 1'b1;
      end
      default: begin  // Sign, code 3 included
        fill_h = half_raw[15];
        fill_b = byte_raw[7];
      end
    endcase
  end

  always_comb begin
    case (data_type_q)
      DT_WORD: begin
        // Nonzero offset only on the second half of a split word
        rdata_ext = (rdata_offset_q == 2'b00) ? resp_rdata_i : rdata_joined[31:0];
      end
      DT_HALF: rdata_ext = {{16{fill_h}}, half_raw};
      default: rdata_ext = {{24{fill_b}}, byte_raw};  // Byte, code 3 included
    endcase
  end

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (resp_valid_i && !data_we_q) begin
      if (data_misaligned_ex_i || misaligned_i) begin
        rdata_q <= resp_rdata_i;  // First half, raw for assembly
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  assign data_rdata_o = resp_valid_i ? rdata_ext : rdata_q;  // Live on rvalid

  // A response needs WB attributes from an earlier handover
  a_resp_after_update : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> seen_update_q);

endmodule

`default_nettype wire

/* src/lsu_outstanding_ctrl.sv */
// LSU outstanding transaction control
`timescale 1ns/1ns
`default_nettype none

module lsu_outstanding_ctrl #(
  parameter int unsigned DEPTH = lsu_pkg::LSU_DEPTH  // Max in-flight transactions
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           data_req_i,      // Request from EX
  input  logic           data_we_i,
  input  lsu_pkg::word_t trans_addr_i,
  input  lsu_pkg::word_t trans_wdata_i,
  input  lsu_pkg::be_t   trans_be_i,
  input  logic           data_gnt_i,
  input  logic           data_rvalid_i,
  output logic           data_req_o,
  output lsu_pkg::word_t data_addr_o,
  output logic           data_we_o,
  output lsu_pkg::be_t   data_be_o,
  output lsu_pkg::word_t data_wdata_o,
  output logic           ctrl_update_o,   // Access moves from EX to WB
  output logic           lsu_ready_ex_o,
  output logic           lsu_ready_wb_o,
  output logic           busy_o
);

  import lsu_pkg::*;

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [CNT_W-1:0] cnt_q;     // Accepted but unanswered
  logic [CNT_W-1:0] cnt_d;
  logic             trans_valid;
  logic             count_up;
  logic             count_down;

  //////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////

  // No issue once DEPTH are in flight, no path from rvalid
  assign trans_valid = data_req_i && (cnt_q < DEPTH);

  assign data_req_o   = trans_valid;
  assign data_addr_o  = trans_addr_i;   // EX holds these until handover
  assign data_we_o    = data_we_i;
  assign data_be_o    = trans_be_i;
  assign data_wdata_o = trans_wdata_i;

  assign count_up   = trans_valid && data_gnt_i;  // Address phase done
  assign count_down = data_rvalid_i;              // Response phase done

  //////////////////////////////////////////////////
  // Ready and busy
  //////////////////////////////////////////////////

  // WB free when empty, else frees on the awaited response
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // EX and WB advance in lock step once WB is occupied
  always_comb begin
    if (!data_req_i) begin
      lsu_ready_ex_o = 1'b1;
    end else if (cnt_q == '0) begin
      lsu_ready_ex_o = count_up;
    end else if (cnt_q == CNT_W'(1)) begin
      lsu_ready_ex_o = count_up && data_rvalid_i;
    end else begin
      lsu_ready_ex_o = data_rvalid_i;  // Already accepted, wait for WB
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_i;
  assign busy_o        = (cnt_q != '0) || trans_valid;

  //////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    if (count_up && !count_down) cnt_d = cnt_q + 1'b1;
    if (!count_up && count_down) cnt_d = cnt_q - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Limit holds across issue and response traffic
  a_cnt_bound : assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= DEPTH);

  // Memory must not answer what was never accepted
  a_no_spurious_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));

  // EX keeps the access stable until the grant arrives
  a_addr_phase_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o)));

endmodule

`default_nettype wire

/* src/lsu_top.sv */
// LSU top level
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
  parameter int unsigned DEPTH = lsu_pkg::LSU_DEPTH  // Max in-flight transactions
) (
  input  logic                clk,
  input  logic                rst_n,

  // Data bus
  output logic                data_req_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  output lsu_pkg::word_t      data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::word_t      data_wdata_o,
  input  lsu_pkg::word_t      data_rdata_i,

  // EX stage
  input  logic                data_we_ex_i,
  input  lsu_pkg::data_type_e data_type_ex_i,
  input  lsu_pkg::word_t      data_wdata_ex_i,
  input  lsu_pkg::byte_off_t  data_reg_offset_ex_i,
  input  lsu_pkg::sign_ext_e  data_sign_ext_ex_i,
  output lsu_pkg::word_t      data_rdata_ex_o,       // Load result
  input  logic                data_req_ex_i,
  input  lsu_pkg::word_t      operand_a_ex_i,
  input  lsu_pkg::word_t      operand_b_ex_i,
  input  logic                addr_useincr_ex_i,     // A + B, else A alone
  input  logic                data_misaligned_ex_i,  // Second half in EX
  output logic                data_misaligned_o,     // Split access found
  output logic                lsu_ready_ex_o,
  output logic                lsu_ready_wb_o,
  output logic                busy_o
);

  lsu_pkg::word_t     trans_addr;
  lsu_pkg::be_t       trans_be;
  lsu_pkg::word_t     trans_wdata;
  lsu_pkg::byte_off_t addr_offset;
  logic               ctrl_update;  // EX to WB handover

  lsu_request_gen u_request_gen (
    .operand_a_i      (operand_a_ex_i),
    .operand_b_i      (operand_b_ex_i),
    .addr_useincr_i   (addr_useincr_ex_i),
    .data_type_i      (data_type_ex_i),
    .data_wdata_i     (data_wdata_ex_i),
    .data_reg_offset_i(data_reg_offset_ex_i),
    .data_req_i       (data_req_ex_i),
    .data_misaligned_i(data_misaligned_ex_i),
    .trans_addr_o     (trans_addr),
    .trans_be_o       (trans_be),
    .trans_wdata_o    (trans_wdata),
    .addr_offset_o    (addr_offset),
    .misaligned_o     (data_misaligned_o)
  );

  lsu_outstanding_ctrl #(
    .DEPTH(DEPTH)
  ) u_outstanding_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_i    (data_req_ex_i),
    .data_we_i     (data_we_ex_i),
    .trans_addr_i  (trans_addr),
    .trans_wdata_i (trans_wdata),
    .trans_be_i    (trans_be),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .ctrl_update_o (ctrl_update),
    .lsu_ready_ex_o(lsu_ready_ex_o),
    .lsu_ready_wb_o(lsu_ready_wb_o),
    .busy_o        (busy_o)
  );

  lsu_read_align u_read_align (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_update_i       (ctrl_update),
    .data_type_i         (data_type_ex_i),
    .data_sign_ext_i     (data_sign_ext_ex_i),
    .addr_offset_i       (addr_offset),
    .data_we_i           (data_we_ex_i),
    .data_misaligned_ex_i(data_misaligned_ex_i),
    .misaligned_i        (data_misaligned_o),
    .resp_valid_i        (data_rvalid_i),
    .resp_rdata_i        (data_rdata_i),
    .data_rdata_o        (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

/* bench/lsu_mem_model.sv */
// Data bus memory responder
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_model #(
  parameter int unsigned MEM_BYTES = 1024  // Byte array size, addresses wrap
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [7:0]  mem [0:MEM_BYTES-1];
  logic [1:0]  gnt_wait_q;        // Cycles left before the next grant
  logic [31:0] rdata_q [$];       // Responses waiting, oldest first
  int unsigned due_q [$];         // Cycle each response may show
  int unsigned cyc;
  int unsigned last_due;
  int unsigned base;
  logic [31:0] rd_word;

  // Initial image, every address bit takes part
  initial begin
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = 8'((i * 37) ^ (i >> 3) ^ 8'hc5);
    end
  end

  assign gnt_o = req_i && (gnt_wait_q == 2'd0);

  //////////////////////////////////////////////////
  // Accept and answer
  //////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait_q <= '0;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
      rdata_q.delete();
      due_q.delete();
      cyc      = 0;
      last_due = 0;
    end else begin
      cyc = cyc + 1;
      if (rvalid_o) begin  // Response taken in the cycle just ended
        void'(rdata_q.pop_front());
        void'(due_q.pop_front());
      end
      if (req_i && gnt_o) begin
        base = ({addr_i[31:2], 2'b00}) % MEM_BYTES;
        for (int j = 0; j < 4; j++) begin
          if (we_i && be_i[j]) mem[base + j] = wdata_i[8*j +: 8];
          rd_word[8*j +: 8] = mem[base + j];
        end
        // In order, and never two in one cycle
        last_due = cyc + $urandom_range(1, 3);
        if (due_q.size() > 0 && last_due <= due_q[$]) last_due = due_q[$] + 1;
        rdata_q.push_back(rd_word);
        due_q.push_back(last_due);
        gnt_wait_q <= 2'($urandom_range(0, 3));
      end else if (req_i && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        rvalid_o <= 1'b1;
        rdata_o  <= rdata_q[0];
      end else begin
        rvalid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/lsu_tb.sv */
// LSU testbench
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;

  import lsu_pkg::*;

  localparam int unsigned DEPTH        = lsu_pkg::LSU_DEPTH;
  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 4;
  localparam int          N_ACCESS     = 300;
  localparam int          CYC_PER_ACC  = 24;  // Two halves with worst grant and response
  localparam int          MEM_BYTES    = 1024;
  localparam int          TIMEOUT_NS   = (RESET_CYCLES + N_ACCESS * CYC_PER_ACC + 50) * CLK_PERIOD;

  logic clk = 1'b0;
  logic rst_n;

  logic       data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  word_t      data_addr_o, data_wdata_o, data_rdata_i, data_rdata_ex_o;
  be_t        data_be_o;
  logic       data_we_ex_i, data_req_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  data_type_e data_type_ex_i;
  sign_ext_e  data_sign_ext_ex_i;
  word_t      data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  byte_off_t  data_reg_offset_ex_i;
  logic       data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;

  // Reference memory and current EX access
  logic [7:0]  ref_mem [0:MEM_BYTES-1];
  logic [31:0] acc_addr, acc_wdata, acc_load_exp, op_a, op_b;
  logic [1:0]  acc_type, acc_ext, acc_roff;
  logic        acc_we, acc_split, acc_incr, active, phase;
  int          acc_size;
  int          issued_trans, accepted_trans, resp_cnt, done_acc, outstanding;
  bit          resp_chk_q [$];  // Response carries a final load result
  logic [31:0] resp_exp_q [$];

  always #(CLK_PERIOD / 2) clk = ~clk;

  lsu_top #(.DEPTH(DEPTH)) dut_i (
    .clk(clk), .rst_n(rst_n),
    .data_req_o(data_req_o), .data_gnt_i(data_gnt_i), .data_rvalid_i(data_rvalid_i),
    .data_addr_o(data_addr_o), .data_we_o(data_we_o), .data_be_o(data_be_o),
    .data_wdata_o(data_wdata_o), .data_rdata_i(data_rdata_i),
    .data_we_ex_i(data_we_ex_i), .data_type_ex_i(data_type_ex_i),
    .data_wdata_ex_i(data_wdata_ex_i), .data_reg_offset_ex_i(data_reg_offset_ex_i),
    .data_sign_ext_ex_i(data_sign_ext_ex_i), .data_rdata_ex_o(data_rdata_ex_o),
    .data_req_ex_i(data_req_ex_i), .operand_a_ex_i(operand_a_ex_i),
    .operand_b_ex_i(operand_b_ex_i), .addr_useincr_ex_i(addr_useincr_ex_i),
    .data_misaligned_ex_i(data_misaligned_ex_i), .data_misaligned_o(data_misaligned_o),
    .lsu_ready_ex_o(lsu_ready_ex_o), .lsu_ready_wb_o(lsu_ready_wb_o), .busy_o(busy_o)
  );

  lsu_mem_model #(.MEM_BYTES(MEM_BYTES)) u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(data_req_o), .addr_i(data_addr_o), .we_i(data_we_o),
    .be_i(data_be_o), .wdata_i(data_wdata_o), .gnt_o(data_gnt_i),
    .rvalid_o(data_rvalid_i), .rdata_o(data_rdata_i)
  );

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  function automatic int size_of(input logic [1:0] t);
    return (t == 2'd0) ? 4 : (t == 2'd1) ? 2 : 1;  // Code 3 is a byte
  endfunction

  function automatic logic [31:0] extend(input logic [31:0] raw, input int size,
                                         input logic [1:0] ext);
    logic fill;
    fill = (ext == 2'd0) ? 1'b0 : (ext == 2'd2) ? 1'b1 : (size == 2 ? raw[15] : raw[7]);
    if (size == 4) return raw;
    if (size == 2) return {{16{fill}}, raw[15:0]};
    return {{24{fill}}, raw[7:0]};
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] a, input int size);
    logic [31:0] raw;
    raw = '0;
    for (int k = 0; k < size; k++) raw[8*k +: 8] = ref_mem[a + k];  // Little endian
    return raw;
  endfunction

  // Lanes of word wbase that fall inside the access
  function automatic logic [3:0] lanes_of(input logic [31:0] a, input int size,
                                          input logic [31:0] wbase);
    logic [3:0] be;
    be = '0;
    for (int j = 0; j < 4; j++) begin
      if (wbase + j >= a && wbase + j < a + size) be[j] = 1'b1;
    end
    return be;
  endfunction

  task automatic new_access();
    int unsigned b;
    acc_type  = 2'($urandom_range(0, 3));
    acc_size  = size_of(acc_type);
    acc_addr  = $urandom_range(0, MEM_BYTES - 8);
    acc_we    = 1'($urandom_range(0, 1));
    acc_ext   = 2'($urandom_range(0, 3));
    acc_wdata = $urandom();
    acc_roff  = 2'($urandom_range(0, 3));
    acc_incr  = 1'($urandom_range(0, 1));
    acc_split = (acc_size == 4 && acc_addr[1:0] != 2'd0) ||
                (acc_size == 2 && acc_addr[1:0] == 2'd3);
    b    = $urandom_range(0, acc_addr);
    op_b = acc_incr ? b : $urandom();
    op_a = acc_incr ? acc_addr - b : acc_addr;
    acc_load_exp = extend(ref_load(acc_addr, acc_size), acc_size, acc_ext);
    phase  = 1'b0;
    active = 1'b1;
    issued_trans += acc_split ? 2 : 1;
  endtask

  //////////////////////////////////////////////////
  // One clock cycle as the EX stage
  //////////////////////////////////////////////////

  task automatic step(input bit allow_new);
    logic [31:0] wbase, mask, exp_w;
    logic [3:0]  be;
    bit          acc_now;
    bit          exp_req;
    bit          exp_acc;
    bit          exp_rdy;
    int          k;
    @(negedge clk);
    if (allow_new && !active && $urandom_range(0, 3) != 0) new_access();
    data_req_ex_i        = active;
    data_we_ex_i         = acc_we;
    data_type_ex_i       = data_type_e'(acc_type);
    data_sign_ext_ex_i   = sign_ext_e'(acc_ext);
    data_wdata_ex_i      = acc_wdata;
    data_reg_offset_ex_i = acc_roff;
    operand_a_ex_i       = op_a;
    operand_b_ex_i       = op_b;
    addr_useincr_ex_i    = acc_incr;
    data_misaligned_ex_i = active && phase;
    #1;
    exp_req = active && (outstanding < DEPTH);  // Held back once DEPTH are in flight
    exp_acc = exp_req && data_gnt_i;
    if (!active) begin
      exp_rdy = 1'b1;
    end else if (outstanding == 0) begin
      exp_rdy = exp_acc;
    end else if (outstanding == 1) begin
      exp_rdy = exp_acc && data_rvalid_i;
    end else begin
      exp_rdy = data_rvalid_i;  // WB full, EX waits on the oldest response
    end
    check_val("data_req_o", exp_req, data_req_o);
    check_val("lsu_ready_ex_o", exp_rdy, lsu_ready_ex_o);
    check_val("busy_o", (outstanding != 0) || active, busy_o);
    check_val("lsu_ready_wb_o", (outstanding == 0) ? 1 : data_rvalid_i, lsu_ready_wb_o);
    if (active) check_val("data_misaligned_o", !phase && acc_split, data_misaligned_o);
    acc_now = data_req_o && data_gnt_i;
    if (acc_now) begin
      accepted_trans++;
      wbase = phase ? ((acc_addr >> 2) + 1) << 2 : {acc_addr[31:2], 2'b00};
      be    = lanes_of(acc_addr, acc_size, wbase);
      check_val("data_addr_o", phase ? wbase : acc_addr, data_addr_o);
      check_val("data_we_o", acc_we, data_we_o);
      check_val("data_be_o", be, data_be_o);
      if (acc_we) begin
        mask  = '0;
        exp_w = '0;
        for (int j = 0; j < 4; j++) begin
          if (be[j]) begin
            k = wbase + j - acc_addr;  // Position inside the access
            mask[8*j +: 8]  = 8'hff;
            exp_w[8*j +: 8] = acc_wdata[8*((acc_roff + k) % 4) +: 8];
          end
        end
        check_val("data_wdata_o", exp_w, data_wdata_o & mask);
      end
      resp_chk_q.push_back(!acc_we && (phase || !acc_split));
      resp_exp_q.push_back(acc_load_exp);
    end
    if (data_rvalid_i) begin
      if (resp_chk_q.size() == 0) begin
        $display("Response arrived with no transaction outstanding at %0t ns", $time);
        $display("Test FAILED");
        $fatal(1);
      end
      resp_cnt++;
      if (resp_chk_q.pop_front()) begin
        check_val("data_rdata_ex_o", resp_exp_q.pop_front(), data_rdata_ex_o);
      end else begin
        void'(resp_exp_q.pop_front());
      end
    end
    outstanding += (acc_now ? 1 : 0) - (data_rvalid_i ? 1 : 0);
    // Handover at the coming rising edge
    if (active && lsu_ready_ex_o) begin
      if (!phase && acc_split) begin
        phase    = 1'b1;
        op_a     = acc_addr + 4;  // Next word with the offset bits kept
        op_b     = $urandom();
        acc_incr = 1'b0;
      end else begin
        if (acc_we) begin
          for (int n = 0; n < acc_size; n++) begin
            ref_mem[acc_addr + n] = acc_wdata[8*((acc_roff + n) % 4) +: 8];
          end
        end
        active = 1'b0;
        done_acc++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Run
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(27));
    active = 1'b0;
    phase  = 1'b0;
    {acc_addr, acc_wdata, acc_load_exp, op_a, op_b} = '0;
    {acc_type, acc_ext, acc_roff, acc_we, acc_split, acc_incr} = '0;
    acc_size = 1;
    {issued_trans, accepted_trans, resp_cnt, done_acc, outstanding} = '0;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = DT_WORD;
    data_sign_ext_ex_i = EXT_ZERO;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = '0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = u_mem.mem[i];  // Same start image
    #1;
    check_val("data_req_o", 0, data_req_o);
    check_val("busy_o", 0, busy_o);
    check_val("lsu_ready_ex_o", 1, lsu_ready_ex_o);
    check_val("lsu_ready_wb_o", 1, lsu_ready_wb_o);
    while (done_acc < N_ACCESS) step(done_acc + (active ? 1 : 0) < N_ACCESS);
    while (outstanding != 0) step(1'b0);
    step(1'b0);  // Idle cycle after the drain
    check_val("accepted transactions", issued_trans, accepted_trans);
    check_val("responses", issued_trans, resp_cnt);
    check_val("busy_o", 0, busy_o);
    check_val("lsu_ready_ex_o", 1, lsu_ready_ex_o);
    $display("Test OK");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the accesses did not complete in %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* list.f */
src/lsu_pkg.sv
src/lsu_request_gen.sv
src/lsu_read_align.sv
src/lsu_outstanding_ctrl.sv
src/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' list.f)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

run: $(SIM)
	-$(SIM) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
